//--- hw/pm_pkg.sv
// shared widths and defaults for the microinstruction cycle sequencer
// every file refers to these by scoped name
// tick_t bounds the KC and PC pulse lengths

`default_nettype none

package pm_pkg;

	// group counter value selecting one of four register groups
	typedef logic [1:0] lg_t;

	// step counter value
	typedef logic [3:0] lk_t;

	// three-bit instruction field
	// bit 2 is the leftmost IR bit (IR7 for the group field)
	typedef logic [2:0] ir_field_t;

	// general register address
	typedef logic [2:0] reg_sel_t;

	// pulse-length down-counter
	typedef logic [7:0] tick_t;

	// default cycle-end and cycle-start pulse lengths, in clock cycles
	localparam int DEF_KC_TICKS = 3;
	localparam int DEF_PC_TICKS = 2;

endpackage

`default_nettype wire

//--- hw/cycle_ctl.sv
// START, WAIT and CYCLE flip-flops on the input side of the sequencer
// turns operator and program levels into the run level and the
// cycle and interrupt requests for the KC/PC generator

`default_nettype none

module cycle_ctl (
	input  logic __clk,
	input  logic clm,
	input  logic start,
	input  logic stop,
	input  logic clo,
	input  logic hlt,
	input  logic wx,
	input  logic cycle,
	input  logic irq,
	input  logic rescyc,
	input  logic si1_pulse,
	output logic run,
	output logic halted,
	output logic dpr,
	output logic dprzerw
);

	logic start_q;
	logic wait_q;
	logic cycle_q;
	logic run_clr;

	// stop and clo kill the run state at once
	assign run_clr = clm | stop | clo;

	always_ff @(posedge __clk or posedge run_clr) begin
		if (run_clr) begin
			start_q <= 1'b0;
		end else if (start) begin
			start_q <= 1'b1;
		end
	end

	// halt loaded at wx and released when an interrupt is taken
	always_ff @(posedge __clk or posedge run_clr) begin
		if (run_clr) begin
			wait_q <= 1'b0;
		end else if (si1_pulse) begin
			wait_q <= 1'b0;
		end else if (wx) begin
			wait_q <= hlt;
		end
	end

	// single-cycle request where set wins over rescyc
	always_ff @(posedge __clk or posedge clm) begin
		if (clm) begin
			cycle_q <= 1'b0;
		end else if (cycle) begin
			cycle_q <= 1'b1;
		end else if (rescyc) begin
			cycle_q <= 1'b0;
		end
	end

	assign run = start_q & ~wait_q;
	assign halted = wait_q;
	assign dpr = run | cycle_q;
	// interrupt taken only while started or stepping
	assign dprzerw = (cycle_q | start_q) & irq;

endmodule

`default_nettype wire

//--- hw/kcpc.sv
// KC/PC pulse generator giving cycle end followed by cycle start
// ekc starts KC; on its last cycle a pending request carries on into PC
// PR and PRZERW latch the kind of the new cycle at PC entry
// pulse lengths come from KC_TICKS and PC_TICKS

`default_nettype none

module kcpc #(
	parameter int KC_TICKS = pm_pkg::DEF_KC_TICKS,
	parameter int PC_TICKS = pm_pkg::DEF_PC_TICKS
) (
	input  logic __clk,
	input  logic clm,
	input  logic clo,
	input  logic ekc,
	input  logic dpr,
	input  logic dprzerw,
	output logic kc,
	output logic pc,
	output logic pr,
	output logic przerw,
	output logic rescyc,
	output logic si1_pulse
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_KC,
		S_PC
	} state_t;

	state_t state;
	pm_pkg::tick_t ticks;
	logic last_tick;

	assign last_tick = (ticks == '0);

	always_ff @(posedge __clk or posedge clm) begin
		if (clm) begin
			state <= S_IDLE;
			ticks <= '0;
			pr <= 1'b0;
			przerw <= 1'b0;
			rescyc <= 1'b0;
		end else begin
			// rescyc lives only for the first PC cycle
			rescyc <= 1'b0;
			case (state)
				S_IDLE: begin
					if (ekc) begin
						state <= S_KC;
						ticks <= pm_pkg::tick_t'(KC_TICKS - 1);
					end
				end
				S_KC: begin
					if (clo) begin
						// clear aborts the cycle end
						state <= S_IDLE;
					end else if (!last_tick) begin
						ticks <= ticks - 1'b1;
					end else if (dpr | dprzerw) begin
						state <= S_PC;
						ticks <= pm_pkg::tick_t'(PC_TICKS - 1);
						// interrupt request beats fetch
						pr <= dpr & ~dprzerw;
						przerw <= dprzerw;
						rescyc <= 1'b1;
					end else begin
						state <= S_IDLE;
					end
				end
				S_PC: begin
					if (last_tick) begin
						state <= S_IDLE;
					end else begin
						ticks <= ticks - 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign kc = (state == S_KC);
	assign pc = (state == S_PC);
	// interrupt cycle start releases WAIT
	assign si1_pulse = pc & przerw;

endmodule

`default_nettype wire

//--- hw/lg.sv
// group counter LG
// preloaded from the instruction group field, stepped modulo 4
// reset beats load, load beats increment

`default_nettype none

module lg (
	input  logic              __clk,
	input  logic              clm,
	input  logic              load,
	input  logic              inc,
	input  logic              gr,
	input  pm_pkg::ir_field_t ir_group,
	output pm_pkg::lg_t       count
);

	pm_pkg::lg_t preload;

	// register group ops take IR8..9 directly
	// everything else starts at 0 or 1 from IR7
	always_comb begin
		if (gr) begin
			preload = ir_group[1:0];
		end else begin
			preload = {1'b0, ir_group[2]};
		end
	end

	always_ff @(posedge __clk or posedge clm) begin
		if (clm) begin
			count <= '0;
		end else if (load) begin
			count <= preload;
		end else if (inc) begin
			// wraps 3 -> 0
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/lk.sv
// step counter LK
// four-bit down-counter that sticks at zero
// nonzero tells the sequencer that steps remain

`default_nettype none

module lk (
	input  logic        __clk,
	input  logic        clm,
	input  logic        load,
	input  logic        dec,
	input  pm_pkg::lk_t value,
	output logic        nonzero
);

	pm_pkg::lk_t count;

	always_ff @(posedge __clk or posedge clm) begin
		if (clm) begin
			count <= '0;
		end else if (load) begin
			count <= value;
		end else if (dec && count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign nonzero = (count != '0);

endmodule

`default_nettype wire

//--- hw/pm_select.sv
// output decode of the cycle-start strobes, one-hot group and register selector
// purely combinational and fed by the KC/PC levels and the group counter

`default_nettype none

module pm_select (
	input  logic               pc,
	input  logic               pr,
	input  logic               przerw,
	input  logic               p3,
	input  logic               p4,
	input  logic               w,
	input  pm_pkg::ir_field_t  ir_a,
	input  pm_pkg::ir_field_t  ir_b,
	input  pm_pkg::lg_t        group,
	output logic               sp0,
	output logic               sp1,
	output logic               si1,
	output logic [3:0]         lg_hot,
	output pm_pkg::reg_sel_t   reg_sel
);

	// start of a plain cycle
	assign sp0 = pc & ~pr & ~przerw;
	// start of an instruction fetch
	assign sp1 = pc & pr & ~przerw;
	// start of an interrupt receive
	assign si1 = pc & przerw;

	assign lg_hot = 4'b0001 << group;

	// P3 register field first, then P4, then the group register
	always_comb begin
		if (p3) begin
			reg_sel = ir_a;
		end else if (p4) begin
			reg_sel = ir_b;
		end else if (w) begin
			reg_sel = {1'b0, group};
		end else begin
			reg_sel = '0;
		end
	end

endmodule

`default_nettype wire

//--- hw/pm.sv
// microinstruction unit cycle-sequencing core
// ties the START/WAIT/CYCLE logic, the KC/PC generator, the group
// and step counters and the output decode together
// KC_TICKS and PC_TICKS set the pulse lengths in clock cycles

`default_nettype none

module pm #(
	parameter int KC_TICKS = pm_pkg::DEF_KC_TICKS,
	parameter int PC_TICKS = pm_pkg::DEF_PC_TICKS
) (
	input  logic              __clk,
	input  logic              clm,
	input  logic              start,
	input  logic              stop,
	input  logic              clo,
	input  logic              hlt,
	input  logic              wx,
	input  logic              cycle,
	input  logic              irq,
	input  logic              ekc,
	input  logic              lg_load,
	input  logic              lg_inc,
	input  logic              gr,
	input  pm_pkg::ir_field_t ir_group,
	input  logic              lk_load,
	input  logic              lk_dec,
	input  pm_pkg::lk_t       lk_value,
	input  logic              p3,
	input  logic              p4,
	input  logic              w,
	input  pm_pkg::ir_field_t ir_a,
	input  pm_pkg::ir_field_t ir_b,
	output logic              run,
	output logic              halted,
	output logic              sp0,
	output logic              sp1,
	output logic              si1,
	output logic [3:0]        lg_hot,
	output pm_pkg::reg_sel_t  reg_sel,
	output logic              lk_nonzero
);

	logic dpr;
	logic dprzerw;
	logic rescyc;
	logic si1_pulse;
	logic pc;
	logic pr;
	logic przerw;
	pm_pkg::lg_t group;

	cycle_ctl cycle_ctl_inst (
		.__clk     (__clk),
		.clm       (clm),
		.start     (start),
		.stop      (stop),
		.clo       (clo),
		.hlt       (hlt),
		.wx        (wx),
		.cycle     (cycle),
		.irq       (irq),
		.rescyc    (rescyc),
		.si1_pulse (si1_pulse),
		.run       (run),
		.halted    (halted),
		.dpr       (dpr),
		.dprzerw   (dprzerw)
	);

	// only pc drives the decode so the kc level has no user here
	kcpc #(
		.KC_TICKS (KC_TICKS),
		.PC_TICKS (PC_TICKS)
	) kcpc_inst (
		.__clk     (__clk),
		.clm       (clm),
		.clo       (clo),
		.ekc       (ekc),
		.dpr       (dpr),
		.dprzerw   (dprzerw),
		.kc        (),
		.pc        (pc),
		.pr        (pr),
		.przerw    (przerw),
		.rescyc    (rescyc),
		.si1_pulse (si1_pulse)
	);

	lg lg_inst (
		.__clk    (__clk),
		.clm      (clm),
		.load     (lg_load),
		.inc      (lg_inc),
		.gr       (gr),
		.ir_group (ir_group),
		.count    (group)
	);

	lk lk_inst (
		.__clk   (__clk),
		.clm     (clm),
		.load    (lk_load),
		.dec     (lk_dec),
		.value   (lk_value),
		.nonzero (lk_nonzero)
	);

	pm_select pm_select_inst (
		.pc      (pc),
		.pr      (pr),
		.przerw  (przerw),
		.p3      (p3),
		.p4      (p4),
		.w       (w),
		.ir_a    (ir_a),
		.ir_b    (ir_b),
		.group   (group),
		.sp0     (sp0),
		.sp1     (sp1),
		.si1     (si1),
		.lg_hot  (lg_hot),
		.reg_sel (reg_sel)
	);

endmodule

`default_nettype wire

//--- tb/pm_checker.sv
// concurrent assertions on the pm outputs
// bound into every pm instance

`default_nettype none

module pm_checker (
	input logic       __clk,
	input logic       clm,
	input logic       run,
	input logic       halted,
	input logic       sp0,
	input logic       sp1,
	input logic       si1,
	input logic [3:0] lg_hot
);
	timeunit 1ns;
	timeprecision 100ps;

	// at most one kind of cycle start at a time
	strobes_exclusive: assert property (@(posedge __clk) disable iff (clm)
		$onehot0({sp0, sp1, si1}))
		else $error("more than one cycle-start strobe active");

	// a waiting machine is never running
	run_not_halted: assert property (@(posedge __clk) disable iff (clm)
		!(run && halted))
		else $error("run and halted both high");

	// exactly one group selected
	group_one_hot: assert property (@(posedge __clk) disable iff (clm)
		$onehot(lg_hot))
		else $error("lg_hot is not one-hot");

endmodule

bind pm pm_checker pm_checker_inst (
	.__clk  (__clk),
	.clm    (clm),
	.run    (run),
	.halted (halted),
	.sp0    (sp0),
	.sp1    (sp1),
	.si1    (si1),
	.lg_hot (lg_hot)
);

`default_nettype wire

//--- tb/pm_tb.sv
// testbench for the pm cycle-sequencing core
// one step per line of tb/pm_stimulus.txt gives the inputs and expected outputs
// each step drives inputs 1 ns after a rising edge, waits its cycle count,
// then compares the outputs 1 ns after the last of those edges

`default_nettype none

module pm_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int KC_TICKS = 3;
	localparam int PC_TICKS = 2;
	localparam int RESET_CYCLES = 5;
	// 20 inputs, wait count, 8 expected outputs
	localparam int FIELDS = 29;
	localparam int WAIT_FIELD = 20;
	localparam int SLACK_CYCLES = 50;

	logic __clk;
	logic clm;
	logic start;
	logic stop;
	logic clo;
	logic hlt;
	logic wx;
	logic cycle;
	logic irq;
	logic ekc;
	logic lg_load;
	logic lg_inc;
	logic gr;
	pm_pkg::ir_field_t ir_group;
	logic lk_load;
	logic lk_dec;
	pm_pkg::lk_t lk_value;
	logic p3;
	logic p4;
	logic w;
	pm_pkg::ir_field_t ir_a;
	pm_pkg::ir_field_t ir_b;
	logic run;
	logic halted;
	logic sp0;
	logic sp1;
	logic si1;
	logic [3:0] lg_hot;
	pm_pkg::reg_sel_t reg_sel;
	logic lk_nonzero;

	// all steps flattened with FIELDS values per step
	int step_data[$];
	int line_fields[$];
	int step_count;
	int cycle_limit = 1000;
	int cycle_count = 0;
	int checks;
	int errors;

	pm #(
		.KC_TICKS (KC_TICKS),
		.PC_TICKS (PC_TICKS)
	) pm_inst (
		.__clk      (__clk),
		.clm        (clm),
		.start      (start),
		.stop       (stop),
		.clo        (clo),
		.hlt        (hlt),
		.wx         (wx),
		.cycle      (cycle),
		.irq        (irq),
		.ekc        (ekc),
		.lg_load    (lg_load),
		.lg_inc     (lg_inc),
		.gr         (gr),
		.ir_group   (ir_group),
		.lk_load    (lk_load),
		.lk_dec     (lk_dec),
		.lk_value   (lk_value),
		.p3         (p3),
		.p4         (p4),
		.w          (w),
		.ir_a       (ir_a),
		.ir_b       (ir_b),
		.run        (run),
		.halted     (halted),
		.sp0        (sp0),
		.sp1        (sp1),
		.si1        (si1),
		.lg_hot     (lg_hot),
		.reg_sel    (reg_sel),
		.lk_nonzero (lk_nonzero)
	);

	// 4 ns period
	always #2 __clk = ~__clk;

	// run limit from the summed step waits
	always @(posedge __clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: stimulus still running after %0d cycles", cycle_count);
			errors++;
			finish_run();
		end
	end

	// value of one hex character or -1 for anything else
	function automatic int hex_digit(byte c);
		if (c >= 8'h30 && c <= 8'h39) begin
			return int'(c) - 48;
		end else if (c >= 8'h61 && c <= 8'h66) begin
			return int'(c) - 87;
		end else if (c >= 8'h41 && c <= 8'h46) begin
			return int'(c) - 55;
		end
		return -1;
	endfunction

	// hex tokens of one line go into line_fields up to a '#'
	task automatic split_fields(input string line);
		int i;
		int acc;
		int digit;
		bit in_token;
		byte c;
		line_fields.delete();
		acc = 0;
		in_token = 1'b0;
		for (i = 0; i < line.len(); i++) begin
			c = line[i];
			if (c == 8'h23) begin
				break;
			end
			digit = hex_digit(c);
			if (digit >= 0) begin
				acc = acc * 16 + digit;
				in_token = 1'b1;
			end else if (in_token) begin
				line_fields.push_back(acc);
				acc = 0;
				in_token = 1'b0;
			end
		end
		if (in_token) begin
			line_fields.push_back(acc);
		end
	endtask

	task automatic read_stimulus(output bit ok);
		int fd;
		int got;
		int line_no;
		string line;
		ok = 1'b1;
		line_no = 0;
		fd = $fopen("tb/pm_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/pm_stimulus.txt");
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				got = $fgets(line, fd);
				line_no++;
				if (got > 0) begin
					split_fields(line);
					if (line_fields.size() == FIELDS && line_fields[WAIT_FIELD] >= 1) begin
						foreach (line_fields[k]) begin
							step_data.push_back(line_fields[k]);
						end
					end else if (line_fields.size() != 0) begin
						// wrong field count or a zero wait
						$display("stimulus line %0d is malformed", line_no);
						ok = 1'b0;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_step(input int base);
		start = 1'(step_data[base + 0]);
		stop = 1'(step_data[base + 1]);
		clo = 1'(step_data[base + 2]);
		hlt = 1'(step_data[base + 3]);
		wx = 1'(step_data[base + 4]);
		cycle = 1'(step_data[base + 5]);
		irq = 1'(step_data[base + 6]);
		ekc = 1'(step_data[base + 7]);
		lg_load = 1'(step_data[base + 8]);
		lg_inc = 1'(step_data[base + 9]);
		gr = 1'(step_data[base + 10]);
		ir_group = 3'(step_data[base + 11]);
		lk_load = 1'(step_data[base + 12]);
		lk_dec = 1'(step_data[base + 13]);
		lk_value = 4'(step_data[base + 14]);
		p3 = 1'(step_data[base + 15]);
		p4 = 1'(step_data[base + 16]);
		w = 1'(step_data[base + 17]);
		ir_a = 3'(step_data[base + 18]);
		ir_b = 3'(step_data[base + 19]);
	endtask

	task automatic check_value(input string name, input int expected, input logic [3:0] actual);
		checks++;
		if (actual !== 4'(expected)) begin
			errors++;
			$display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic check_step(input int base);
		check_value("run", step_data[base + 21], {3'b000, run});
		check_value("halted", step_data[base + 22], {3'b000, halted});
		check_value("sp0", step_data[base + 23], {3'b000, sp0});
		check_value("sp1", step_data[base + 24], {3'b000, sp1});
		check_value("si1", step_data[base + 25], {3'b000, si1});
		check_value("lg_hot", step_data[base + 26], lg_hot);
		check_value("reg_sel", step_data[base + 27], {1'b0, reg_sel});
		check_value("lk_nonzero", step_data[base + 28], {3'b000, lk_nonzero});
	endtask

	task finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	initial begin : main
		bit loaded;
		int base;
		int total_wait;
		int s;
		__clk = 1'b0;
		clm = 1'b1;
		start = 1'b0;
		stop = 1'b0;
		clo = 1'b0;
		hlt = 1'b0;
		wx = 1'b0;
		cycle = 1'b0;
		irq = 1'b0;
		ekc = 1'b0;
		lg_load = 1'b0;
		lg_inc = 1'b0;
		gr = 1'b0;
		ir_group = '0;
		lk_load = 1'b0;
		lk_dec = 1'b0;
		lk_value = '0;
		p3 = 1'b0;
		p4 = 1'b0;
		w = 1'b0;
		ir_a = '0;
		ir_b = '0;
		checks = 0;
		errors = 0;
		read_stimulus(loaded);
		step_count = step_data.size() / FIELDS;
		total_wait = 0;
		for (s = 0; s < step_count; s++) begin
			total_wait += step_data[s * FIELDS + WAIT_FIELD];
		end
		cycle_limit = RESET_CYCLES + total_wait + SLACK_CYCLES;
		if (!loaded || step_count == 0) begin
			$display("no usable stimulus steps, nothing was run");
			errors++;
		end else begin
			repeat (RESET_CYCLES) @(posedge __clk);
			#1;
			clm = 1'b0;
			for (s = 0; s < step_count; s++) begin
				base = s * FIELDS;
				apply_step(base);
				repeat (step_data[base + WAIT_FIELD]) @(posedge __clk);
				#1;
				check_step(base);
			end
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/pm_pkg.sv
hw/cycle_ctl.sv
hw/kcpc.sv
hw/lg.sv
hw/lk.sv
hw/pm_select.sv
hw/pm.sv
tb/pm_checker.sv
tb/pm_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the pm testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module pm_tb -o pm_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/pm_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1

//--- tb/pm_stimulus.txt
# inputs: st sp co hl wx cy iq ek gl gi gr ig kl kd kv p3 p4 w ia ib | wait cycles (>= 1)
# expected after the wait: run halted sp0 sp1 si1 lg_hot reg_sel lk_nonzero
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 1 0 0  # after reset
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 1 0 0 0 0 1 0 0  # start
0 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 1 0 0 0 1 0 0  # hlt with wx
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 1 0 0  # stop
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 1 0 0 0 0 1 0 0  # run again
0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 1 0 0 0 0 1 0 0  # ekc, fetch
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 2 | 1 0 0 0 0 1 0 0  # still KC
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 1 0 0 1 0 1 0 0  # PC cycle 4
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 1 0 0 1 0 1 0 0  # PC cycle 5
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 1 0 0 0 0 1 0 0  # idle
0 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 1 0 0 0 1 0 0  # halt
0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 1 0 0 0 1 0 0  # ekc with irq
0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 | 3 | 0 1 0 0 1 1 0 0  # interrupt PC
0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 1 0 0 0 1 1 0 0  # wait released
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 1 0 0 0 0 1 0 0
0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 1 0 0  # stop
0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 1 0 0  # single cycle
0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 1 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 3 | 0 0 0 1 0 1 0 0  # pr from dpr
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 2 | 0 0 0 0 0 1 0 0
0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 1 0 0  # ekc, no request
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 4 | 0 0 0 0 0 1 0 0  # no strobe
0 0 0 0 0 0 0 0 1 0 1 6 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 4 0 0  # load gr
0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 8 0 0
0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 1 0 0  # wrap
0 0 0 0 0 0 0 0 1 0 0 4 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 2 0 0  # load IR7
0 0 0 0 0 0 0 0 1 1 0 3 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 1 0 0  # load beats inc
0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 2 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 5 3 | 1 | 0 0 0 0 0 2 5 0  # P3 first
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 5 3 | 1 | 0 0 0 0 0 2 3 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 5 3 | 1 | 0 0 0 0 0 2 1 0  # group in W
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5 3 | 1 | 0 0 0 0 0 2 0 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 3 0 0 0 0 0 | 1 | 0 0 0 0 0 2 0 1  # lk load 3
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 | 2 | 0 0 0 0 0 2 0 1
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 | 1 | 0 0 0 0 0 2 0 0  # third dec
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 | 2 | 0 0 0 0 0 2 0 0  # holds at zero
0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 0 0 0 0 | 1 | 0 0 0 0 0 2 0 1  # load beats dec
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 | 1 | 0 0 0 0 0 2 0 0
0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 2 0 0  # cycle request
0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 2 0 0
0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 1 | 0 0 0 0 0 2 0 0  # clo aborts KC
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 | 4 | 0 0 0 0 0 2 0 0
